//--- source/nnPkg.sv
package nnPkg;

    ////////////////////
    // Number format
    ////////////////////

    // Signed Q7.24 words
    localparam int DataWidth = 32;
    localparam int FracBits = 24;

    typedef logic signed [DataWidth-1:0] fixed_t;

    // Saturation limits
    localparam fixed_t FixedMax = 32'sh7FFF_FFFF;
    localparam fixed_t FixedMin = 32'sh8000_0000;

    // Neuron index, caps the network at 16 neurons
    typedef logic [3:0] neuronIdx_t;

    ////////////////////
    // Address map
    ////////////////////

    localparam int AddrWidth = 9;

    typedef logic [AddrWidth-1:0] addr_t;

    localparam addr_t AddrWeightInBase = 9'd0;
    localparam addr_t AddrWeightOutBase = 9'd16;
    localparam addr_t AddrOffset = 9'd32;
    // Write only, a write starts an evaluation
    localparam addr_t AddrInput = 9'd33;
    localparam addr_t AddrResult = 9'd48;
    localparam addr_t AddrStatus = 9'd49;

    // Status word, done in bit 0
    typedef struct packed {
        logic [DataWidth-4:0] reserved;
        logic busy;
        logic error;
        logic done;
    } statusWord_t;

    // Item carried between pipeline stages
    typedef struct packed {
        logic valid;
        neuronIdx_t idx;
        fixed_t value;
    } stageItem_t;

    ////////////////////
    // Pipeline and activation
    ////////////////////

    localparam int PipeDepth = 4;
    localparam int NumSegments = 8;

    // Upper bound of each segment, last one open ended
    localparam fixed_t pwlBreak [NumSegments] = '{
        32'shFE00_0000, 32'shFF00_0000, 32'shFF80_0000, 32'sh0000_0000,
        32'sh0080_0000, 32'sh0100_0000, 32'sh0200_0000, FixedMax
    };

    // Slopes 0, 7/32, 5/8, 15/16 mirrored around zero
    localparam fixed_t pwlSlope [NumSegments] = '{
        32'sh0000_0000, 32'sh0038_0000, 32'sh00A0_0000, 32'sh00F0_0000,
        32'sh00F0_0000, 32'sh00A0_0000, 32'sh0038_0000, 32'sh0000_0000
    };

    // Intercepts chosen so the curve is continuous and ends at +-1.0
    localparam fixed_t pwlIntercept [NumSegments] = '{
        32'shFF00_0000, 32'shFF70_0000, 32'shFFD8_0000, 32'sh0000_0000,
        32'sh0000_0000, 32'sh0028_0000, 32'sh0090_0000, 32'sh0100_0000
    };

    // Saturating add, clamps like the multiply
    function automatic fixed_t satAdd(input fixed_t a, input fixed_t b, output logic overflow);
        logic signed [DataWidth:0] sum;
        sum = {a[DataWidth-1], a} + {b[DataWidth-1], b};
        // Carry into the extra bit disagrees with the sign bit
        overflow = sum[DataWidth] != sum[DataWidth-1];
        if (!overflow) begin
            return sum[DataWidth-1:0];
        end
        return sum[DataWidth] ? FixedMin : FixedMax;
    endfunction

endpackage

//--- source/fixedMul.sv
`timescale 1ns/1ns

module fixedMul (
    input  nnPkg::fixed_t a,
    input  nnPkg::fixed_t b,
    output nnPkg::fixed_t product,
    output logic overflow
);

    localparam int FullWidth = 2 * nnPkg::DataWidth;

    // Full width product and the realigned value
    logic signed [FullWidth-1:0] full;
    logic signed [FullWidth-1:0] shifted;
    // Bits above the Q7.24 result, sign included
    logic [FullWidth-nnPkg::DataWidth:0] upper;

    always_comb begin
        full = a * b;
        // Drop the extra fraction bits, keep the sign
        shifted = full >>> nnPkg::FracBits;
        upper = shifted[FullWidth-1:nnPkg::DataWidth-1];
    end

    always_comb begin
        // Fits only if all upper bits match the sign
        overflow = !((&upper) || (~|upper));
        if (!overflow) begin
            product = shifted[nnPkg::DataWidth-1:0];
        end else if (shifted[FullWidth-1]) begin
            product = nnPkg::FixedMin;
        end else begin
            product = nnPkg::FixedMax;
        end
    end

endmodule

//--- source/pwlActivation.sv
`timescale 1ns/1ns

module pwlActivation (
    input  nnPkg::fixed_t x,
    output nnPkg::fixed_t y,
    output logic overflow
);

    localparam int SegBits = $clog2(nnPkg::NumSegments);

    // Selected segment
    logic [SegBits-1:0] seg;
    nnPkg::fixed_t slope;
    nnPkg::fixed_t intercept;

    // Slope times x
    nnPkg::fixed_t scaled;
    logic mulOverflow;
    logic addOverflow;

    ////////////////////
    // Segment search
    ////////////////////

    always_comb begin
        // Falls into the last segment unless a lower bound matches
        seg = SegBits'(nnPkg::NumSegments - 1);
        // Walk downward so the lowest matching segment wins
        for (int k = nnPkg::NumSegments - 2; k >= 0; k--) begin
            if (x < nnPkg::pwlBreak[k]) begin
                seg = SegBits'(k);
            end
        end
        slope = nnPkg::pwlSlope[seg];
        intercept = nnPkg::pwlIntercept[seg];
    end

    ////////////////////
    // Line evaluation
    ////////////////////

    fixedMul slopeMul_i (
        .a(slope),
        .b(x),
        .product(scaled),
        .overflow(mulOverflow)
    );

    always_comb begin
        y = nnPkg::satAdd(scaled, intercept, addOverflow);
        // Either step may clamp
        overflow = mulOverflow | addOverflow;
    end

endmodule

//--- source/nnDatapath.sv
`timescale 1ns/1ns

module nnDatapath #(
    parameter int NumNeurons = 10
) (
    input  logic CLK,
    input  logic rst,
    input  logic accClear,
    input  nnPkg::stageItem_t issue,
    input  nnPkg::fixed_t weightIn [NumNeurons],
    input  nnPkg::fixed_t weightOut [NumNeurons],
    input  nnPkg::fixed_t offset,
    input  nnPkg::fixed_t inputX,
    output nnPkg::fixed_t result,
    output logic error
);

    // Stage registers, stage 4 is the accumulator itself
    nnPkg::stageItem_t s1;
    nnPkg::stageItem_t s2;
    nnPkg::stageItem_t s3;

    // Combinational results feeding each stage
    nnPkg::fixed_t hiddenSum;
    nnPkg::fixed_t hiddenAct;
    nnPkg::fixed_t weighted;
    nnPkg::fixed_t accNext;

    logic inOverflow;
    logic actOverflow;
    logic outOverflow;
    logic addOverflow;
    logic anyOverflow;

    ////////////////////
    // Stage logic
    ////////////////////

    // wIn of the issued neuron times x
    fixedMul inMul_i (
        .a(weightIn[issue.idx]),
        .b(inputX),
        .product(hiddenSum),
        .overflow(inOverflow)
    );

    pwlActivation act_i (
        .x(s1.value),
        .y(hiddenAct),
        .overflow(actOverflow)
    );

    // wOut picked by the item's own index
    fixedMul outMul_i (
        .a(weightOut[s2.idx]),
        .b(s2.value),
        .product(weighted),
        .overflow(outOverflow)
    );

    always_comb begin
        accNext = nnPkg::satAdd(result, s3.value, addOverflow);
        // Flags count only for real items
        anyOverflow = (inOverflow & issue.valid) | (actOverflow & s1.valid)
                    | (outOverflow & s2.valid) | (addOverflow & s3.valid);
    end

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            s1 <= '0;
            s2 <= '0;
            s3 <= '0;
        end else begin
            s1 <= '{valid: issue.valid, idx: issue.idx, value: hiddenSum};
            s2 <= '{valid: s1.valid, idx: s1.idx, value: hiddenAct};
            s3 <= '{valid: s2.valid, idx: s2.idx, value: weighted};
        end
    end

    // Accumulator starts from the offset
    always_ff @(posedge CLK) begin
        if (rst) begin
            result <= '0;
            error <= 1'b0;
        end else if (accClear) begin
            result <= offset;
            error <= 1'b0;
        end else begin
            if (s3.valid) begin
                result <= accNext;
            end
            // Sticky until the next evaluation
            error <= error | anyOverflow;
        end
    end

endmodule

//--- source/nnSequencer.sv
`timescale 1ns/1ns

module nnSequencer #(
    parameter int NumNeurons = 10
) (
    input  logic CLK,
    input  logic rst,
    input  logic start,
    output nnPkg::stageItem_t issue,
    output logic accClear,
    output logic busy,
    output logic done
);

    localparam int DrainBits = $clog2(nnPkg::PipeDepth);
    localparam logic [DrainBits-1:0] DrainLast = DrainBits'(nnPkg::PipeDepth - 1);
    localparam nnPkg::neuronIdx_t LastNeuron = nnPkg::neuronIdx_t'(NumNeurons - 1);

    typedef enum logic [1:0] {
        Idle,
        Issue,
        Drain
    } state_t;

    state_t state;
    nnPkg::neuronIdx_t idxCnt;
    logic [DrainBits-1:0] drainCnt;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= Idle;
            idxCnt <= '0;
            drainCnt <= '0;
            issue <= '0;
            accClear <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            // One cycle pulse by default
            accClear <= 1'b0;
            issue.valid <= 1'b0;
            issue.value <= '0;
            case (state)
                Idle: begin
                    if (start) begin
                        state <= Issue;
                        idxCnt <= '0;
                        accClear <= 1'b1;
                        busy <= 1'b1;
                        done <= 1'b0;
                    end
                end
                Issue: begin
                    // One neuron per cycle
                    issue.valid <= 1'b1;
                    issue.idx <= idxCnt;
                    idxCnt <= idxCnt + 1'b1;
                    if (idxCnt == LastNeuron) begin
                        state <= Drain;
                        drainCnt <= '0;
                    end
                end
                Drain: begin
                    // Last item reaches the accumulator on the final drain edge
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == DrainLast) begin
                        state <= Idle;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

//--- source/nnRegisterFile.sv
`timescale 1ns/1ns

module nnRegisterFile #(
    parameter int NumNeurons = 10
) (
    input  logic CLK,
    input  logic rst,
    input  logic write,
    input  logic read,
    input  nnPkg::addr_t address,
    input  nnPkg::fixed_t writedata,
    input  logic busy,
    input  logic done,
    input  logic error,
    input  nnPkg::fixed_t result,
    output nnPkg::fixed_t readdata,
    output nnPkg::fixed_t weightIn [NumNeurons],
    output nnPkg::fixed_t weightOut [NumNeurons],
    output nnPkg::fixed_t offset,
    output nnPkg::fixed_t inputX,
    output logic start
);

    // Accepted write
    logic writeOk;
    nnPkg::statusWord_t status;

    // The start cycle is locked out too, busy rises one edge later
    assign writeOk = write && !busy && !start;

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < NumNeurons; i++) begin
                weightIn[i] <= '0;
                weightOut[i] <= '0;
            end
            offset <= '0;
            inputX <= '0;
            start <= 1'b0;
        end else begin
            start <= writeOk && (address == nnPkg::AddrInput);
            if (writeOk) begin
                // Coefficient banks
                for (int i = 0; i < NumNeurons; i++) begin
                    if (address == nnPkg::addr_t'(nnPkg::AddrWeightInBase + i)) begin
                        weightIn[i] <= writedata;
                    end
                    if (address == nnPkg::addr_t'(nnPkg::AddrWeightOutBase + i)) begin
                        weightOut[i] <= writedata;
                    end
                end
                if (address == nnPkg::AddrOffset) begin
                    offset <= writedata;
                end
                if (address == nnPkg::AddrInput) begin
                    inputX <= writedata;
                end
            end
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    always_comb begin
        status = '0;
        status.done = done;
        status.error = error;
        status.busy = busy;
    end

    // Unmapped and write-only addresses read as zero
    always_comb begin
        readdata = '0;
        if (read) begin
            case (address)
                nnPkg::AddrOffset: readdata = offset;
                nnPkg::AddrResult: readdata = result;
                nnPkg::AddrStatus: readdata = nnPkg::fixed_t'(status);
                default: readdata = '0;
            endcase
            for (int i = 0; i < NumNeurons; i++) begin
                if (address == nnPkg::addr_t'(nnPkg::AddrWeightInBase + i)) begin
                    readdata = weightIn[i];
                end
                if (address == nnPkg::addr_t'(nnPkg::AddrWeightOutBase + i)) begin
                    readdata = weightOut[i];
                end
            end
        end
    end

endmodule

//--- source/nnTop.sv
`timescale 1ns/1ns

module nnTop #(
    parameter int NumNeurons = 10
) (
    input  logic CLK,
    input  logic rst,
    input  logic write,
    input  logic read,
    input  nnPkg::addr_t address,
    input  nnPkg::fixed_t writedata,
    output nnPkg::fixed_t readdata
);

    // Coefficients and input from the bus registers
    nnPkg::fixed_t weightIn [NumNeurons];
    nnPkg::fixed_t weightOut [NumNeurons];
    nnPkg::fixed_t offset;
    nnPkg::fixed_t inputX;

    // Control between blocks
    logic start;
    logic busy;
    logic done;
    logic accClear;
    nnPkg::stageItem_t issue;

    // Datapath outputs
    nnPkg::fixed_t result;
    logic error;

    nnRegisterFile #(.NumNeurons(NumNeurons)) regFile_i (
        .CLK(CLK), .rst(rst), .write(write), .read(read),
        .address(address), .writedata(writedata),
        .busy(busy), .done(done), .error(error), .result(result),
        .readdata(readdata), .weightIn(weightIn), .weightOut(weightOut),
        .offset(offset), .inputX(inputX), .start(start)
    );

    nnSequencer #(.NumNeurons(NumNeurons)) seq_i (
        .CLK(CLK), .rst(rst), .start(start), .issue(issue),
        .accClear(accClear), .busy(busy), .done(done)
    );

    nnDatapath #(.NumNeurons(NumNeurons)) datapath_i (
        .CLK(CLK), .rst(rst), .accClear(accClear), .issue(issue),
        .weightIn(weightIn), .weightOut(weightOut),
        .offset(offset), .inputX(inputX),
        .result(result), .error(error)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int Period = 40,
    parameter int ResetCycles = 16
) (
    output logic CLK,
    output logic rst
);

    // Free running clock
    initial begin
        CLK = 1'b0;
        forever begin
            #(Period / 2) CLK = ~CLK;
        end
    end

    // Reset drops on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
    end

endmodule

//--- tb/nnRefModel.svh
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

// Golden model of the network
// Reads NumNeurons, wInModel, wOutModel and offsetModel of the including module

// Full product realigned to Q7.24, clamped to the word range
function automatic nnPkg::fixed_t satProduct(input nnPkg::fixed_t a, input nnPkg::fixed_t b,
                                             output bit ovf);
    longint full;
    longint scaled;
    full = longint'(a) * longint'(b);
    scaled = full >>> nnPkg::FracBits;
    ovf = 1'b1;
    if (scaled > longint'(nnPkg::FixedMax)) begin
        return nnPkg::FixedMax;
    end
    if (scaled < longint'(nnPkg::FixedMin)) begin
        return nnPkg::FixedMin;
    end
    ovf = 1'b0;
    return nnPkg::fixed_t'(scaled);
endfunction

// Wide sum, same clamping
function automatic nnPkg::fixed_t satSum(input nnPkg::fixed_t a, input nnPkg::fixed_t b,
                                         output bit ovf);
    longint sum;
    sum = longint'(a) + longint'(b);
    ovf = 1'b1;
    if (sum > longint'(nnPkg::FixedMax)) begin
        return nnPkg::FixedMax;
    end
    if (sum < longint'(nnPkg::FixedMin)) begin
        return nnPkg::FixedMin;
    end
    ovf = 1'b0;
    return nnPkg::fixed_t'(sum);
endfunction

// Lowest segment whose bound lies above x, else the last one
function automatic nnPkg::fixed_t activation(input nnPkg::fixed_t x, output bit ovf);
    int seg;
    bit found;
    bit mulOvf;
    bit addOvf;
    nnPkg::fixed_t scaled;
    seg = nnPkg::NumSegments - 1;
    found = 1'b0;
    for (int k = 0; k < nnPkg::NumSegments; k++) begin
        if (!found && x < nnPkg::pwlBreak[k]) begin
            seg = k;
            found = 1'b1;
        end
    end
    scaled = satProduct(nnPkg::pwlSlope[seg], x, mulOvf);
    activation = satSum(scaled, nnPkg::pwlIntercept[seg], addOvf);
    ovf = mulOvf | addOvf;
endfunction

// Whole network, neurons summed in index order onto the offset
function automatic nnPkg::fixed_t networkValue(input nnPkg::fixed_t x, output bit ovf);
    nnPkg::fixed_t acc;
    nnPkg::fixed_t hidden;
    nnPkg::fixed_t term;
    bit inOvf;
    bit actOvf;
    bit outOvf;
    bit addOvf;
    acc = offsetModel;
    ovf = 1'b0;
    for (int i = 0; i < NumNeurons; i++) begin
        hidden = activation(satProduct(wInModel[i], x, inOvf), actOvf);
        term = satProduct(wOutModel[i], hidden, outOvf);
        acc = satSum(acc, term, addOvf);
        // Any clamp anywhere sets the flag
        ovf = ovf | inOvf | actOvf | outOvf | addOvf;
    end
    return acc;
endfunction

`endif

//--- tb/nnTb.sv
`timescale 1ns/1ns

module nnTb;

    localparam int NumNeurons = 10;
    localparam int ClockPeriod = 40;
    localparam int ResetCycles = 16;
    localparam int unsigned Seed = 32'h17cd_b820;

    // Evaluation count drives the watchdog budget
    localparam int NumRandomEvals = 4;
    localparam int NumSweepEvals = 2 * (nnPkg::NumSegments - 1);
    localparam int NumEvals = NumRandomEvals + NumSweepEvals + 3;
    localparam int WatchdogCycles = NumEvals * (NumNeurons + 30) + 200;
    localparam int DonePollLimit = NumNeurons + 10;

    // Handy Q7.24 constants
    localparam nnPkg::fixed_t One = 32'sh0100_0000;
    localparam nnPkg::fixed_t Half = 32'sh0080_0000;
    localparam nnPkg::fixed_t Hundred = 32'sh6400_0000;
    localparam nnPkg::fixed_t SweepStep = 32'sh0001_0000;
    localparam int unsigned SmallSpan = 32'h0200_0000;

    // Holes in the map, plus the write only input
    localparam nnPkg::addr_t Unmapped [6] = '{9'd33, 9'd34, 9'd47, 9'd50, 9'd200, 9'd511};

    logic CLK;
    logic rst;
    logic write;
    logic read;
    nnPkg::addr_t address;
    nnPkg::fixed_t writedata;
    nnPkg::fixed_t readdata;

    // Shadow of what the DUT should hold
    nnPkg::fixed_t wInModel [NumNeurons];
    nnPkg::fixed_t wOutModel [NumNeurons];
    nnPkg::fixed_t offsetModel;

    // Expected values queued for the compare process
    nnPkg::fixed_t expResult [$];
    bit expError [$];
    int startedCount = 0;
    int checkedCount = 0;
    int checkCount = 0;
    int errorCount = 0;

    `include "nnRefModel.svh"

    clockGen #(.Period(ClockPeriod), .ResetCycles(ResetCycles)) clock_i (.CLK(CLK), .rst(rst));

    nnTop #(.NumNeurons(NumNeurons)) dut_i (
        .CLK(CLK), .rst(rst), .write(write), .read(read),
        .address(address), .writedata(writedata), .readdata(readdata)
    );

    ////////////////////
    // Bus access
    ////////////////////

    // One cycle write strobe
    task automatic busWrite(input nnPkg::addr_t addr, input nnPkg::fixed_t data);
        @(negedge CLK);
        write = 1'b1;
        address = addr;
        writedata = data;
        @(negedge CLK);
        write = 1'b0;
    endtask

    // Sampled a quarter period later, well before the next edge
    task automatic busRead(input nnPkg::addr_t addr, output nnPkg::fixed_t data);
        @(negedge CLK);
        read = 1'b1;
        address = addr;
        #(ClockPeriod / 4);
        data = readdata;
        read = 1'b0;
    endtask

    task automatic setWeightIn(input int i, input nnPkg::fixed_t v);
        busWrite(nnPkg::addr_t'(nnPkg::AddrWeightInBase + i), v);
        wInModel[i] = v;
    endtask

    task automatic setWeightOut(input int i, input nnPkg::fixed_t v);
        busWrite(nnPkg::addr_t'(nnPkg::AddrWeightOutBase + i), v);
        wOutModel[i] = v;
    endtask

    task automatic setOffset(input nnPkg::fixed_t v);
        busWrite(nnPkg::AddrOffset, v);
        offsetModel = v;
    endtask

    // Uniform value in [-span, span)
    function automatic nnPkg::fixed_t randomInRange(input int unsigned span);
        return nnPkg::fixed_t'(int'($urandom % (2 * span)) - int'(span));
    endfunction

    task automatic loadRandomWeights(input int unsigned span);
        for (int i = 0; i < NumNeurons; i++) begin
            setWeightIn(i, randomInRange(span));
            setWeightOut(i, randomInRange(span));
        end
        setOffset(randomInRange(span / 2));
    endtask

    ////////////////////
    // Evaluation and checks
    ////////////////////

    task automatic launchEval(input nnPkg::fixed_t x, input nnPkg::fixed_t exp, input bit err);
        expResult.push_back(exp);
        expError.push_back(err);
        busWrite(nnPkg::AddrInput, x);
    endtask

    // Hand over to the compare process and wait for its verdict
    task automatic awaitCheck();
        startedCount++;
        wait (checkedCount == startedCount);
    endtask

    task automatic evaluateNetwork(input nnPkg::fixed_t x);
        nnPkg::fixed_t exp;
        bit err;
        exp = networkValue(x, err);
        launchEval(x, exp, err);
        awaitCheck();
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    // Finished evaluation, idle
    function automatic nnPkg::fixed_t doneStatus(input bit err);
        nnPkg::statusWord_t st;
        st = '0;
        st.done = 1'b1;
        st.error = err;
        return nnPkg::fixed_t'(st);
    endfunction

    task automatic finishRun();
        $display("nnTb: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    ////////////////////
    // Compare process
    ////////////////////

    initial begin : compare
        nnPkg::fixed_t value;
        nnPkg::fixed_t exp;
        nnPkg::statusWord_t st;
        bit err;
        int polls;
        forever begin
            wait (checkedCount < startedCount);
            exp = expResult.pop_front();
            err = expError.pop_front();
            // Done drops one edge after start, so the first poll sees it low
            polls = 0;
            st = '0;
            while (!st.done && polls < DonePollLimit) begin
                busRead(nnPkg::AddrStatus, value);
                st = value;
                polls++;
            end
            if (!st.done) begin
                $display("Evaluation %0d: done never rose within %0d cycles",
                         checkedCount, DonePollLimit);
                errorCount++;
            end else begin
                busRead(nnPkg::AddrResult, value);
                checkValue("result", value, exp);
                checkValue("status", st, doneStatus(err));
            end
            checkedCount++;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        nnPkg::fixed_t value;
        nnPkg::fixed_t x;
        nnPkg::fixed_t exp;
        nnPkg::statusWord_t st;
        bit err;
        write = 1'b0;
        read = 1'b0;
        address = '0;
        writedata = '0;
        void'($urandom(Seed));
        wait (rst == 1'b0);

        // Everything reads zero out of reset
        busRead(nnPkg::AddrResult, value);
        checkValue("result", value, '0);
        busRead(nnPkg::AddrStatus, value);
        checkValue("status", value, '0);
        for (int i = 0; i < NumNeurons; i++) begin
            busRead(nnPkg::addr_t'(nnPkg::AddrWeightInBase + i), value);
            checkValue($sformatf("wIn[%0d]", i), value, '0);
            busRead(nnPkg::addr_t'(nnPkg::AddrWeightOutBase + i), value);
            checkValue($sformatf("wOut[%0d]", i), value, '0);
        end
        busRead(nnPkg::AddrOffset, value);
        checkValue("offset", value, '0);

        // Full range readback, then the holes in the map
        for (int i = 0; i < NumNeurons; i++) begin
            setWeightIn(i, nnPkg::fixed_t'($urandom));
            setWeightOut(i, nnPkg::fixed_t'($urandom));
        end
        setOffset(nnPkg::fixed_t'($urandom));
        for (int i = 0; i < NumNeurons; i++) begin
            busRead(nnPkg::addr_t'(nnPkg::AddrWeightInBase + i), value);
            checkValue($sformatf("wIn[%0d]", i), value, wInModel[i]);
            busRead(nnPkg::addr_t'(nnPkg::AddrWeightOutBase + i), value);
            checkValue($sformatf("wOut[%0d]", i), value, wOutModel[i]);
        end
        busRead(nnPkg::AddrOffset, value);
        checkValue("offset", value, offsetModel);
        // Without a read strobe the bus returns zero
        @(negedge CLK);
        address = nnPkg::AddrOffset;
        #(ClockPeriod / 4);
        checkValue("readdata", readdata, '0);
        foreach (Unmapped[j]) begin
            busRead(Unmapped[j], value);
            checkValue($sformatf("readdata@%0d", Unmapped[j]), value, '0);
        end

        // Small random networks stay clear of saturation
        for (int e = 0; e < NumRandomEvals; e++) begin
            loadRandomWeights(SmallSpan);
            evaluateNetwork(randomInRange(SmallSpan));
        end

        // Single neuron with unit weights exposes the curve
        for (int i = 0; i < NumNeurons; i++) begin
            setWeightIn(i, (i == 0) ? One : '0);
            setWeightOut(i, (i == 0) ? One : '0);
        end
        setOffset('0);
        for (int k = 0; k < nnPkg::NumSegments - 1; k++) begin
            for (int side = 0; side < 2; side++) begin
                x = side ? nnPkg::pwlBreak[k] + SweepStep : nnPkg::pwlBreak[k] - SweepStep;
                exp = activation(x, err);
                launchEval(x, exp, err);
                awaitCheck();
            end
        end

        // Input product clamps, sum clamps too
        for (int i = 0; i < NumNeurons; i++) begin
            setWeightIn(i, Hundred);
            setWeightOut(i, Hundred);
        end
        setOffset(Half);
        evaluateNetwork(Hundred);
        // Zero input keeps every step in range, error clears
        evaluateNetwork('0);

        // Writes during the run must bounce
        loadRandomWeights(SmallSpan);
        x = randomInRange(SmallSpan);
        exp = networkValue(x, err);
        launchEval(x, exp, err);
        busWrite(nnPkg::AddrWeightInBase, wInModel[0] + One);
        busWrite(nnPkg::AddrInput, x + One);
        // Still mid evaluation, busy and nothing done yet
        st = '0;
        st.busy = 1'b1;
        busRead(nnPkg::AddrStatus, value);
        checkValue("status", value, st);
        awaitCheck();
        busRead(nnPkg::AddrWeightInBase, value);
        checkValue("wIn[0]", value, wInModel[0]);
        // No second evaluation may follow
        repeat (DonePollLimit) @(negedge CLK);
        busRead(nnPkg::AddrStatus, value);
        checkValue("status", value, doneStatus(err));
        busRead(nnPkg::AddrResult, value);
        checkValue("result", value, exp);

        finishRun();
    end

    // Budget scales with the number of evaluations
    initial begin : watchdog
        repeat (WatchdogCycles) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
        errorCount++;
        finishRun();
    end

endmodule

//--- build.f
+incdir+tb
source/nnPkg.sv
source/fixedMul.sv
source/pwlActivation.sv
source/nnDatapath.sv
source/nnSequencer.sv
source/nnRegisterFile.sv
source/nnTop.sv
tb/clockGen.sv
tb/nnTb.sv
